//--- Makefile
TOP = vgc_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vgc.f --top-module vgc_top

sim:
	verilator --binary --timing -f vgc.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/vgc_color_pkg.sv
package vgc_color_pkg;

    // 4 bits per channel, as stored in the palette
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

    // 8 bits per channel, video output
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } vid_rgb_t;

    typedef logic [3:0] color_idx_t;

    // palette write strobe, data comes straight off the memory bus
    typedef struct packed {
        logic       we;
        logic       hi_byte;
        color_idx_t idx;
    } pal_wr_t;

    // decoded pixel, active is low outside the shr window
    typedef struct packed {
        logic  active;
        rgb4_t rgb;
    } pix_t;

    // the sixteen fixed iigs colors used for the border
    typedef enum logic [3:0] {
        C_BLACK,
        C_DEEP_RED,
        C_DARK_BLUE,
        C_PURPLE,
        C_DARK_GREEN,
        C_DARK_GRAY,
        C_MEDIUM_BLUE,
        C_LIGHT_BLUE,
        C_BROWN,
        C_ORANGE,
        C_LIGHT_GRAY,
        C_PINK,
        C_GREEN,
        C_YELLOW,
        C_AQUAMARINE,
        C_WHITE
    } color_name_e;

    // rgb of each named color, in enum order
    localparam rgb4_t BORDER_RGB [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd0d,
        12'h070, 12'h555, 12'h22f, 12'h6af,
        12'h852, 12'hf60, 12'haaa, 12'hf98,
        12'h0d0, 12'hff0, 12'h0f9, 12'hfff
    };

endpackage

//--- common/vgc_timing_pkg.sv
package vgc_timing_pkg;

    // byte address into video memory
    typedef logic [22:0] vid_addr_t;

    // beam position as supplied by the external timing generator
    typedef struct packed {
        logic [9:0] h;
        logic [8:0] v;
    } beam_t;

    // scanline control byte, one per active line
    typedef struct packed {
        logic       mode640;
        logic       irq_en;
        logic       fill;
        logic       reserved;
        logic [3:0] pal_sel;
    } scb_t;

    // what the sequencer fetches in a slot
    typedef enum logic [1:0] {
        S_IDLE,
        S_SCB,
        S_PAL,
        S_PIX
    } slot_e;

    // line and frame geometry, in slots and lines
    localparam int H_TOTAL      = 912;
    localparam int H_SCB_SLOT   = 910;
    localparam int V_TOTAL      = 262;
    localparam int ACTIVE_LINES = 200;
    localparam int PIX_SLOTS    = 640;
    localparam int PAL_SLOTS    = 32;

    // linear shr memory map
    localparam int SCB_BASE   = 32'h19D00;
    localparam int PAL_BASE   = 32'h19E00;
    localparam int PIX_BASE   = 32'h12000;
    localparam int LINE_BYTES = 160;
    localparam int PAL_BYTES  = 32;

endpackage

//--- logic/vgc_border_mixer.sv
`timescale 1ns/1ns

module vgc_border_mixer
    import vgc_color_pkg::*;
(
    input  logic        clk_vid,
    input  logic        reset,
    input  logic        ce_pix,
    input  pix_t        pix,
    input  color_name_e border_color,
    output vid_rgb_t    rgb
);

    // replicate a nibble so 4'hf maps to full scale
    function automatic logic [7:0] widen(input logic [3:0] n);
        return {n, n};
    endfunction

    rgb4_t border_rgb;
    rgb4_t sel_rgb;

    assign border_rgb = BORDER_RGB[border_color];
    // border everywhere the decoder has no pixel
    assign sel_rgb    = pix.active ? pix.rgb : border_rgb;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            rgb <= '0;
        end else if (ce_pix) begin
            rgb.r <= widen(sel_rgb.r);
            rgb.g <= widen(sel_rgb.g);
            rgb.b <= widen(sel_rgb.b);
        end
    end

endmodule

//--- logic/vgc_top.sv
`timescale 1ns/1ns

module vgc_top
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
#(
    parameter int LEFT_BORDER = 32,
    parameter int TOP_BORDER  = 16
) (
    input  logic        clk_vid,
    input  logic        reset,
    input  logic        ce_pix,
    input  beam_t       beam,
    input  logic        shrg_enable,
    input  color_name_e border_color,
    input  logic [7:0]  video_data,
    output vid_addr_t   video_addr,
    output vid_rgb_t    rgb,
    output logic        scanline_irq,
    output logic        vbl_irq
);

    scb_t       scb;
    pal_wr_t    pal_wr;
    logic       pix_slot;
    logic [1:0] pix_phase;
    color_idx_t rd_idx;
    rgb4_t      rd_rgb;
    pix_t       pix;

    // fetch schedule, scb and interrupts
    shrg_sequencer #(
        .LEFT_BORDER (LEFT_BORDER),
        .TOP_BORDER  (TOP_BORDER)
    ) u_sequencer (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .beam         (beam),
        .shrg_enable  (shrg_enable),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .pal_wr       (pal_wr),
        .scb          (scb),
        .pix_slot     (pix_slot),
        .pix_phase    (pix_phase),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    shrg_palette u_palette (
        .clk_vid    (clk_vid),
        .reset      (reset),
        .ce_pix     (ce_pix),
        .pal_wr     (pal_wr),
        .video_data (video_data),
        .rd_idx     (rd_idx),
        .rd_rgb     (rd_rgb)
    );

    // first pipeline stage, slot h color lands in pix
    shrg_pixel_decoder u_decoder (
        .clk_vid    (clk_vid),
        .reset      (reset),
        .ce_pix     (ce_pix),
        .video_data (video_data),
        .scb        (scb),
        .pix_slot   (pix_slot),
        .pix_phase  (pix_phase),
        .rd_rgb     (rd_rgb),
        .rd_idx     (rd_idx),
        .pix        (pix)
    );

    // second stage, rgb for slot h valid during slot h+2
    vgc_border_mixer u_mixer (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .pix          (pix),
        .border_color (border_color),
        .rgb          (rgb)
    );

endmodule

//--- shrg/shrg_palette.sv
`timescale 1ns/1ns

module shrg_palette
    import vgc_color_pkg::*;
(
    input  logic       clk_vid,
    input  logic       reset,
    input  logic       ce_pix,
    input  pal_wr_t    pal_wr,
    input  logic [7:0] video_data,
    input  color_idx_t rd_idx,
    output rgb4_t      rd_rgb
);

    // sixteen colors of the line's palette
    rgb4_t entries [16];

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                entries[i] <= '0;
            end
        end else if (ce_pix && pal_wr.we) begin
            if (pal_wr.hi_byte) begin
                // odd byte, red in the low nibble
                entries[pal_wr.idx].r <= video_data[3:0];
            end else begin
                // even byte, green high and blue low
                entries[pal_wr.idx].g <= video_data[7:4];
                entries[pal_wr.idx].b <= video_data[3:0];
            end
        end
    end

    // lookup for the decoder, same slot
    assign rd_rgb = entries[rd_idx];

endmodule

//--- shrg/shrg_pixel_decoder.sv
`timescale 1ns/1ns

module shrg_pixel_decoder
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
(
    input  logic       clk_vid,
    input  logic       reset,
    input  logic       ce_pix,
    input  logic [7:0] video_data,
    input  scb_t       scb,
    input  logic       pix_slot,
    input  logic [1:0] pix_phase,
    input  rgb4_t      rd_rgb,
    output color_idx_t rd_idx,
    output pix_t       pix
);

    color_idx_t nibble;
    color_idx_t idx_320;
    color_idx_t idx_640;
    color_idx_t last_idx;

    // 320 mode, each nibble covers two slots
    assign nibble = pix_phase[1] ? video_data[3:0] : video_data[7:4];

    // 640 mode, two bits per slot
    // each position in the byte has its own palette quarter
    always_comb begin
        case (pix_phase)
            2'd0: idx_640 = {2'b10, video_data[7:6]};
            2'd1: idx_640 = {2'b11, video_data[5:4]};
            2'd2: idx_640 = {2'b00, video_data[3:2]};
            default: idx_640 = {2'b01, video_data[1:0]};
        endcase
    end

    // fill mode repeats the last non-zero color
    assign idx_320 = (scb.fill && nibble == 4'd0) ? last_idx : nibble;
    assign rd_idx  = scb.mode640 ? idx_640 : idx_320;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            last_idx <= '0;
            pix      <= '0;
        end else if (ce_pix) begin
            pix.active <= pix_slot;
            pix.rgb    <= rd_rgb;
            // cleared outside the pixel run so every line starts at index 0
            if (!pix_slot) begin
                last_idx <= '0;
            end else if (!scb.mode640 && nibble != 4'd0) begin
                last_idx <= nibble;
            end
        end
    end

endmodule

//--- shrg/shrg_sequencer.sv
`timescale 1ns/1ns

module shrg_sequencer
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
#(
    parameter int LEFT_BORDER = 32,
    parameter int TOP_BORDER  = 16
) (
    input  logic       clk_vid,
    input  logic       reset,
    input  logic       ce_pix,
    input  beam_t      beam,
    input  logic       shrg_enable,
    input  logic [7:0] video_data,
    output vid_addr_t  video_addr,
    output pal_wr_t    pal_wr,
    output scb_t       scb,
    output logic       pix_slot,
    output logic [1:0] pix_phase,
    output logic       scanline_irq,
    output logic       vbl_irq
);

    // kind of fetch done at a horizontal position
    function automatic slot_e slot_kind(input logic [9:0] h);
        slot_e kind;
        if (int'(h) == H_SCB_SLOT) begin
            kind = S_SCB;
        end else if (int'(h) < PAL_SLOTS) begin
            kind = S_PAL;
        end else if (int'(h) >= LEFT_BORDER && int'(h) < LEFT_BORDER + PIX_SLOTS) begin
            kind = S_PIX;
        end else begin
            kind = S_IDLE;
        end
        return kind;
    endfunction

    function automatic logic line_active(input int v);
        return v >= TOP_BORDER && v < TOP_BORDER + ACTIVE_LINES;
    endfunction

    logic [9:0] next_h;
    logic [8:0] next_v;
    slot_e      cur_kind;
    slot_e      next_kind;
    logic [9:0] pix_offset;
    vid_addr_t  line_base;
    scb_t       scb_in;

    // beam position of the following slot, wrapping line and frame
    always_comb begin
        next_h = beam.h + 10'd1;
        next_v = beam.v;
        if (int'(beam.h) == H_TOTAL - 1) begin
            next_h = '0;
            if (int'(beam.v) == V_TOTAL - 1) begin
                next_v = '0;
            end else begin
                next_v = beam.v + 9'd1;
            end
        end
    end

    assign cur_kind   = slot_kind(beam.h);
    assign next_kind  = slot_kind(next_h);
    // offset of the next slot inside the pixel run
    assign pix_offset = next_h - 10'(LEFT_BORDER);
    // first pixel byte of the current row
    assign line_base  = vid_addr_t'(PIX_BASE + (int'(beam.v) - TOP_BORDER) * LINE_BYTES);
    assign scb_in     = scb_t'(video_data);

    // everything here is set up for the next slot
    always_ff @(posedge clk_vid) begin
        if (reset) begin
            video_addr   <= '0;
            pal_wr       <= '0;
            scb          <= '0;
            pix_slot     <= 1'b0;
            pix_phase    <= 2'd0;
            scanline_irq <= 1'b0;
            vbl_irq      <= 1'b0;
        end else if (ce_pix) begin
            // entry is byte offset / 2, odd byte carries red
            pal_wr <= '{we: 1'b0, hi_byte: next_h[0], idx: next_h[4:1]};
            case (next_kind)
                S_SCB: begin
                    // scb of the line after this one
                    video_addr <= vid_addr_t'(SCB_BASE + int'(beam.v) - TOP_BORDER + 1);
                end
                S_PAL: begin
                    video_addr <= vid_addr_t'(PAL_BASE + int'(scb.pal_sel) * PAL_BYTES
                                              + int'(next_h));
                    pal_wr.we  <= 1'b1;
                end
                S_PIX: begin
                    // one byte serves four slots
                    if (pix_offset == '0) begin
                        video_addr <= line_base;
                    end else if (pix_offset[1:0] == 2'd0) begin
                        video_addr <= video_addr + 23'd1;
                    end
                end
                default: begin
                    video_addr <= video_addr;
                end
            endcase

            pix_slot  <= (next_kind == S_PIX) && line_active(int'(next_v)) && shrg_enable;
            pix_phase <= pix_offset[1:0];
            // high for the whole first line after the window
            vbl_irq   <= int'(next_v) == TOP_BORDER + ACTIVE_LINES;

            // scb arrives on the bus during its slot
            if (cur_kind == S_SCB) begin
                scb <= scb_in;
                if (shrg_enable && scb_in.irq_en && line_active(int'(beam.v) + 1)) begin
                    scanline_irq <= 1'b1;
                end
            end else if (beam.h == 10'd0) begin
                scanline_irq <= 1'b0;
            end
        end
    end

endmodule

//--- verif/vgc_ref.svh
`ifndef VGC_REF_SVH
`define VGC_REF_SVH

// expected video behavior computed from the memory image
// included inside vgc_tb so mem, LEFT_BORDER and TOP_BORDER are visible

function automatic logic line_is_active(input int v);
    return v >= TOP_BORDER && v < TOP_BORDER + ACTIVE_LINES;
endfunction

// nibble n of a row where each byte holds its high nibble first
function automatic logic [3:0] pixel_nibble(input int row, input int n);
    logic [7:0] pix_byte;
    pix_byte = rd_mem(PIX_BASE + row * LINE_BYTES + n / 2);
    return (n % 2 == 0) ? pix_byte[7:4] : pix_byte[3:0];
endfunction

// nearest non-zero nibble to the left on the same line for fill mode
function automatic logic [3:0] last_nonzero_nibble(input int row, input int n);
    logic [3:0] found;
    logic       done;
    found = 4'd0;
    done  = 1'b0;
    for (int m = n - 1; m >= 0 && !done; m--) begin
        if (pixel_nibble(row, m) != 4'd0) begin
            found = pixel_nibble(row, m);
            done  = 1'b1;
        end
    end
    return found;
endfunction

// 4-bit channel to 8 bits so that 4'hf becomes 8'hff
function automatic logic [7:0] scale_channel(input logic [3:0] n);
    return {4'd0, n} * 8'd17;
endfunction

function automatic vid_rgb_t exp_rgb(input beam_t at, input color_name_e border, input logic en);
    int         h;
    int         v;
    int         row;
    int         off;
    int         phase;
    int         idx;
    int         pal_addr;
    scb_t       s;
    logic [7:0] pix_byte;
    logic [7:0] pal_even;
    logic [7:0] pal_odd;
    rgb4_t      c;
    vid_rgb_t   res;
    h = int'(at.h);
    v = int'(at.v);
    c = BORDER_RGB[border];
    if (en && line_is_active(v) && h >= LEFT_BORDER && h < LEFT_BORDER + PIX_SLOTS) begin
        row   = v - TOP_BORDER;
        off   = h - LEFT_BORDER;
        phase = off % 4;
        s     = scb_t'(rd_mem(SCB_BASE + row));
        if (s.mode640) begin
            // two bits per slot msbs first with quarters running 2 3 0 1
            pix_byte = rd_mem(PIX_BASE + row * LINE_BYTES + off / 4);
            idx = ((phase + 2) % 4) * 4 + ((int'(pix_byte) >> (6 - 2 * phase)) & 3);
        end else begin
            idx = int'(pixel_nibble(row, off / 2));
            if (s.fill && idx == 0) begin
                idx = int'(last_nonzero_nibble(row, off / 2));
            end
        end
        // each entry is a gb byte followed by a 0r byte
        pal_addr = PAL_BASE + int'(s.pal_sel) * PAL_BYTES + 2 * idx;
        pal_even = rd_mem(pal_addr);
        pal_odd  = rd_mem(pal_addr + 1);
        c.g = pal_even[7:4];
        c.b = pal_even[3:0];
        c.r = pal_odd[3:0];
    end
    res.r = scale_channel(c.r);
    res.g = scale_channel(c.g);
    res.b = scale_channel(c.b);
    return res;
endfunction

// slots whose bus address the fetch schedule pins down
function automatic logic addr_is_fixed(input beam_t at);
    int   h;
    int   v;
    logic fixed;
    h     = int'(at.h);
    v     = int'(at.v);
    fixed = line_is_active(v)
            && (h < PAL_SLOTS || (h >= LEFT_BORDER && h < LEFT_BORDER + PIX_SLOTS));
    return fixed || h == H_SCB_SLOT;
endfunction

// bus address of a fetch slot
function automatic vid_addr_t exp_addr(input beam_t at);
    int   h;
    int   v;
    int   row;
    int   addr;
    scb_t s;
    h   = int'(at.h);
    v   = int'(at.v);
    row = v - TOP_BORDER;
    if (h == H_SCB_SLOT) begin
        // scb of the following line
        addr = SCB_BASE + row + 1;
    end else if (h < PAL_SLOTS) begin
        s    = scb_t'(rd_mem(SCB_BASE + row));
        addr = PAL_BASE + int'(s.pal_sel) * PAL_BYTES + h;
    end else begin
        // four slots per pixel byte
        addr = PIX_BASE + row * LINE_BYTES + (h - LEFT_BORDER) / 4;
    end
    return vid_addr_t'(addr);
endfunction

// high in the last slot before an irq line and in slot 0 of that line
function automatic logic scanline_irq_due(input beam_t at, input logic en);
    int   h;
    int   v;
    scb_t s;
    logic due;
    h   = int'(at.h);
    v   = int'(at.v);
    due = 1'b0;
    if (h == H_TOTAL - 1 && line_is_active(v + 1)) begin
        s   = scb_t'(rd_mem(SCB_BASE + v + 1 - TOP_BORDER));
        due = en && s.irq_en;
    end else if (h == 0 && line_is_active(v)) begin
        s   = scb_t'(rd_mem(SCB_BASE + v - TOP_BORDER));
        due = en && s.irq_en;
    end
    return due;
endfunction

function automatic logic in_vbl_line(input beam_t at);
    return int'(at.v) == TOP_BORDER + ACTIVE_LINES;
endfunction

`endif

//--- verif/vgc_tb.sv
`timescale 1ns/1ns

module vgc_tb
    import vgc_timing_pkg::*;
    import vgc_color_pkg::*;
();

    localparam int     LEFT_BORDER = 32;
    localparam int     TOP_BORDER  = 16;
    localparam int     CLK_PERIOD  = 40;
    localparam int     NUM_FRAMES  = 5;
    localparam int     MEM_BASE    = 32'h10000;
    // twice the length of all test frames
    localparam longint TIMEOUT_NS  = longint'(2) * NUM_FRAMES * H_TOTAL * V_TOTAL * CLK_PERIOD;

    logic        clk_vid = 1'b0;
    logic        reset;
    logic        ce_pix;
    beam_t       beam;
    logic        shrg_enable;
    color_name_e border_color;
    logic [7:0]  video_data;
    vid_addr_t   video_addr;
    vid_rgb_t    rgb;
    logic        scanline_irq;
    logic        vbl_irq;

    // video memory 10000..1ffff
    logic [7:0]  mem [65536];
    integer      seed;

    // inputs of the last slots since rgb lags the beam by two slots
    beam_t       beam_hist [3];
    color_name_e border_hist [2];
    logic        en_hist [3];
    int          live_slots;

    function automatic logic [7:0] rd_mem(input int addr);
        return mem[16'(addr - MEM_BASE)];
    endfunction

    `include "vgc_ref.svh"

    vgc_top #(
        .LEFT_BORDER (LEFT_BORDER),
        .TOP_BORDER  (TOP_BORDER)
    ) dut0 (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .beam         (beam),
        .shrg_enable  (shrg_enable),
        .border_color (border_color),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .rgb          (rgb),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    always #(CLK_PERIOD / 2) clk_vid = ~clk_vid;

    // asynchronous memory that reads zero outside the bank
    assign video_data = (video_addr[22:16] == 7'h01) ? mem[video_addr[15:0]] : 8'h00;

    task automatic check_rgb(input vid_rgb_t got, input vid_rgb_t exp, input beam_t at);
        if (got !== exp) begin
            $display("Error: rgb = %h, expected %h (slot h=%0d v=%0d)", got, exp, at.h, at.v);
            $display("Simulation FAILED");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_addr(input vid_addr_t got, input vid_addr_t exp, input beam_t at);
        if (got !== exp) begin
            $display("Error: video_addr = %h, expected %h (slot h=%0d v=%0d)", got, exp,
                     at.h, at.v);
            $display("Simulation FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_irq(input string name, input logic got, input logic exp,
                             input beam_t at);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h (slot h=%0d v=%0d)", name, got, exp,
                     at.h, at.v);
            $display("Simulation FAILED");
            $fatal(1, "interrupt mismatch");
        end
    endtask

    task automatic fill_random_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[16'(a)] = 8'($random(seed));
        end
    endtask

    // scbs of all 200 lines with a random palette select
    task automatic prepare_scbs(input logic mode640, input logic fill, input logic random_irq);
        scb_t s;
        for (int row = 0; row < ACTIVE_LINES; row++) begin
            s          = scb_t'(8'($random(seed)));
            s.mode640  = mode640;
            s.fill     = fill;
            s.irq_en   = random_irq & s.irq_en;
            s.reserved = 1'b0;
            mem[16'(SCB_BASE + row - MEM_BASE)] = s;
        end
    endtask

    // sparse clears about half of the nibbles
    task automatic fill_pixels(input logic sparse);
        logic [31:0] r;
        logic [7:0]  b;
        for (int a = PIX_BASE; a < PIX_BASE + ACTIVE_LINES * LINE_BYTES; a++) begin
            r = $random(seed);
            b = r[7:0];
            if (sparse && r[8]) begin
                b[7:4] = 4'd0;
            end
            if (sparse && r[9]) begin
                b[3:0] = 4'd0;
            end
            mem[16'(a - MEM_BASE)] = b;
        end
    endtask

    // one beam slot per clock with a new position on each falling edge
    task automatic run_frame(input logic cycle_border);
        for (int v = 0; v < V_TOTAL; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                beam.h = 10'(h);
                beam.v = 9'(v);
                if (cycle_border && h == 0 && v % 16 == 0) begin
                    border_color = color_name_e'(4'(v / 16));
                end
                @(negedge clk_vid);
            end
        end
    endtask

    // compare at the rising edge while outputs still hold the slot's value
    always @(posedge clk_vid) begin
        beam_hist[2]   = beam_hist[1];
        beam_hist[1]   = beam_hist[0];
        beam_hist[0]   = beam;
        border_hist[1] = border_hist[0];
        border_hist[0] = border_color;
        en_hist[2]     = en_hist[1];
        en_hist[1]     = en_hist[0];
        en_hist[0]     = shrg_enable;
        if (reset) begin
            live_slots = 0;
        end else begin
            if (live_slots < 3) begin
                live_slots++;
            end
            // pipeline is filled two slots after reset
            if (live_slots >= 3) begin
                check_rgb(rgb, exp_rgb(beam_hist[2], border_hist[1], en_hist[2]), beam_hist[2]);
                if (addr_is_fixed(beam_hist[0])) begin
                    check_addr(video_addr, exp_addr(beam_hist[0]), beam_hist[0]);
                end
                check_irq("scanline_irq", scanline_irq,
                          scanline_irq_due(beam_hist[0], shrg_enable), beam_hist[0]);
                check_irq("vbl_irq", vbl_irq, in_vbl_line(beam_hist[0]), beam_hist[0]);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run timed out at %0t ns", $time);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        seed         = 32'h6790;
        reset        = 1'b1;
        ce_pix       = 1'b1;
        beam         = '0;
        shrg_enable  = 1'b0;
        border_color = C_BLACK;
        live_slots   = 0;
        fill_random_memory();
        repeat (10) @(negedge clk_vid);
        reset = 1'b0;

        // shr off with the border color changing every 16 lines
        run_frame(1'b1);

        // 320 mode with random palettes and pixels
        shrg_enable  = 1'b1;
        border_color = C_DARK_BLUE;
        prepare_scbs(1'b0, 1'b0, 1'b0);
        run_frame(1'b0);

        // 320 fill mode over many zero nibbles
        border_color = C_ORANGE;
        fill_pixels(1'b1);
        prepare_scbs(1'b0, 1'b1, 1'b0);
        run_frame(1'b0);

        // 640 mode
        border_color = C_LIGHT_GRAY;
        fill_pixels(1'b0);
        prepare_scbs(1'b1, 1'b0, 1'b0);
        run_frame(1'b0);

        // scanline irqs on random lines
        border_color = C_WHITE;
        prepare_scbs(1'b0, 1'b0, 1'b1);
        run_frame(1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- vgc.f
+incdir+verif
common/vgc_timing_pkg.sv
common/vgc_color_pkg.sv
shrg/shrg_sequencer.sv
shrg/shrg_palette.sv
shrg/shrg_pixel_decoder.sv
logic/vgc_border_mixer.sv
logic/vgc_top.sv
verif/vgc_tb.sv
